// ==== src/rpu_status_pkg.sv ====
/*
 * RPU status channel definitions
 * Address maps for both status directions and the event word layout
 */

package rpu_status_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Interconnect to core

  // Status lines arriving from the interconnect, value 7 is idle
  typedef enum logic [2:0] {
    RX_CONFIG  = 3'd0,
    RX_TIMER_L = 3'd1,
    RX_TIMER_H = 3'd2,
    RX_EVENTS  = 3'd3,
    RX_DEBUG_L = 3'd4,
    RX_DEBUG_H = 3'd5,
    RX_ITEMS   = 3'd6
  } rx_addr_e;

  // Interrupt vector order is evict, poke, inv_desc, inv_slot, dupl_slot
  localparam int INT_COUNT = 5;

  // Event word layout
  localparam int EVT_INT_LSB = 16;
  localparam int EVT_TAG_V   = 21;
  localparam int TAG_WIDTH   = 5;

  ////////////////////////////////////////////////////////////////////////////
  // Core to interconnect

  typedef enum logic [2:0] {
    TX_IDLE    = 3'd0,
    TX_SLOT    = 3'd1,
    TX_DEBUG_L = 3'd2,
    TX_DEBUG_H = 3'd3,
    TX_TAG_LEN = 3'd4
  } tx_addr_e;

endpackage

// ==== src/rpu_desc_pkg.sv ====
/*
 * Descriptor definitions
 * Type codes and field positions of a 64-bit descriptor beat
 */

package rpu_desc_pkg;

  // One beat on the descriptor path
  localparam int DESC_WIDTH = 64;

  // Field positions inside a header beat
  localparam int SLOT_LSB   = 16;
  localparam int TYPE_LSB   = 60;
  localparam int TYPE_WIDTH = 4;

  // Types 0..2 finish a slot, types 4 and 5 carry a DRAM address beat
  typedef enum logic [3:0] {
    DT_SEND_DATA = 4'd0,
    DT_SEND_SLOT = 4'd1,
    DT_SEND_MSG  = 4'd2,
    DT_DRAM_WR   = 4'd4,
    DT_DRAM_RD   = 4'd5
  } desc_type_e;

endpackage

// ==== src/desc_merger.sv ====
/*
 * Descriptor merger
 * Turns a two-word core descriptor into one or two 64-bit beats
 */

`timescale 1ns/1ps

module desc_merger (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [rpu_desc_pkg::DESC_WIDTH-1:0] core_desc_hdr,
  input  logic [rpu_desc_pkg::DESC_WIDTH-1:0] core_desc_dram_addr,
  input  logic                                core_desc_valid,
  output logic                                core_desc_ready,
  output logic [rpu_desc_pkg::DESC_WIDTH-1:0] beat,
  output logic                                beat_2nd,
  output logic                                beat_valid,
  input  logic                                beat_ready
);

  typedef enum logic {
    HDR  = 1'b0,
    ADDR = 1'b1
  } state_e;

  state_e                               state;
  logic   [rpu_desc_pkg::TYPE_WIDTH-1:0] hdr_type;
  logic                                 hdr_is_dram;
  logic                                 xfer;

  // Header type decides whether an address beat follows
  assign hdr_type    = core_desc_hdr[rpu_desc_pkg::TYPE_LSB +: rpu_desc_pkg::TYPE_WIDTH];
  assign hdr_is_dram = (hdr_type == rpu_desc_pkg::DT_DRAM_WR) ||
                       (hdr_type == rpu_desc_pkg::DT_DRAM_RD);

  assign xfer = beat_valid && beat_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= HDR;
    end else if (xfer) begin
      // ADDR always goes back to HDR
      state <= (state == HDR && hdr_is_dram) ? ADDR : HDR;
    end
  end

  // Beat select
  assign beat       = (state == ADDR) ? core_desc_dram_addr : core_desc_hdr;
  assign beat_2nd   = (state == ADDR);
  assign beat_valid = core_desc_valid;

  // Core is held on a DRAM header, released with the address beat
  assign core_desc_ready = (state == HDR && hdr_is_dram) ? 1'b0 : beat_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Checks

  // Core must keep the descriptor in place until the address beat goes out
  a_core_hold: assert property (@(posedge clk) disable iff (rst)
    state == ADDR |-> core_desc_valid && $stable(core_desc_hdr) &&
                      $stable(core_desc_dram_addr));

endmodule

// ==== src/desc_fifo.sv ====
/*
 * Descriptor FIFO
 * Circular buffer of beats plus their second-beat flag
 */

`timescale 1ns/1ps

module desc_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [rpu_desc_pkg::DESC_WIDTH-1:0] beat,
  input  logic                                beat_2nd,
  input  logic                                beat_valid,
  output logic                                beat_ready,
  output logic [rpu_desc_pkg::DESC_WIDTH-1:0] out_desc,
  output logic                                out_desc_2nd,
  output logic                                out_desc_valid,
  input  logic                                out_desc_ready
);

  localparam int ENTRY_W = rpu_desc_pkg::DESC_WIDTH + 1;
  localparam int PTR_W   = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W   = $clog2(FIFO_DEPTH + 1);

  logic [ENTRY_W-1:0] mem [FIFO_DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;
  logic               push;
  logic               pop;

  assign push = beat_valid && beat_ready;
  assign pop  = out_desc_valid && out_desc_ready;

  // Storage written on push only
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= {beat_2nd, beat};
    end
  end

  // Pointers wrap at the depth which need not be a power of two
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leave the count alone
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  assign beat_ready                   = (count != CNT_W'(FIFO_DEPTH));
  assign out_desc_valid               = (count != '0);
  assign {out_desc_2nd, out_desc}     = mem[rd_ptr];

  ////////////////////////////////////////////////////////////////////////////
  // Checks

  // Read pointer plus count lands on the write pointer modulo the depth
  a_count_ptrs: assert property (@(posedge clk) disable iff (rst)
    count <= CNT_W'(FIFO_DEPTH) &&
    (int'(rd_ptr) + int'(count)) % FIFO_DEPTH == int'(wr_ptr));

endmodule

// ==== src/slot_tracker.sv ====
/*
 * Slot tracker
 * One bit per packet slot, set by taken input descriptors, cleared when done
 */

`timescale 1ns/1ps

module slot_tracker #(
  parameter int SLOT_COUNT = 16
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [rpu_desc_pkg::DESC_WIDTH-1:0] in_desc,
  input  logic                                in_desc_valid,
  input  logic                                in_desc_taken,
  input  logic [rpu_desc_pkg::DESC_WIDTH-1:0] out_desc,
  input  logic                                out_desc_2nd,
  input  logic                                out_desc_valid,
  input  logic                                out_desc_ready,
  output logic [SLOT_COUNT:1]                 slots_in_prog
);

  localparam int SLOT_W = $clog2(SLOT_COUNT + 1);

  logic [SLOT_W-1:0]                   in_slot;
  logic [SLOT_W-1:0]                   out_slot;
  logic [rpu_desc_pkg::TYPE_WIDTH-1:0] out_type;
  logic                                set_ev;
  logic                                clr_ev;

  assign in_slot  = in_desc[rpu_desc_pkg::SLOT_LSB +: SLOT_W];
  assign out_slot = out_desc[rpu_desc_pkg::SLOT_LSB +: SLOT_W];
  assign out_type = out_desc[rpu_desc_pkg::TYPE_LSB +: rpu_desc_pkg::TYPE_WIDTH];

  assign set_ev = in_desc_valid && in_desc_taken;

  // Only a header beat of a send type finishes its slot
  assign clr_ev = out_desc_valid && out_desc_ready && !out_desc_2nd &&
                  ((out_type == rpu_desc_pkg::DT_SEND_DATA) ||
                   (out_type == rpu_desc_pkg::DT_SEND_SLOT) ||
                   (out_type == rpu_desc_pkg::DT_SEND_MSG));

  always_ff @(posedge clk) begin
    if (rst) begin
      slots_in_prog <= '0;
    end else begin
      if (set_ev) begin
        slots_in_prog[in_slot] <= 1'b1;
      end
      // Later write, so clear wins on the same slot
      if (clr_ev) begin
        slots_in_prog[out_slot] <= 1'b0;
      end
    end
  end

  a_slot_range: assert property (@(posedge clk) disable iff (rst)
    (set_ev |-> in_slot >= 1 && in_slot <= SLOT_COUNT) and
    (clr_ev |-> out_slot >= 1 && out_slot <= SLOT_COUNT));

endmodule

// ==== src/status_rx.sv ====
/*
 * Inbound status decoder
 * Interconnect status lines into config, timer, counts, tag and interrupts
 */

`timescale 1ns/1ps

module status_rx (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic [2:0]                           intercon_status_addr,
  input  logic [31:0]                          intercon_status_data,
  input  logic [rpu_status_pkg::INT_COUNT-1:0] int_ack,
  output logic [15:0]                          bc_region_size,
  output logic [7:0]                           max_slot_count,
  output logic [7:0]                           core_id,
  output logic [63:0]                          timer,
  output logic [63:0]                          debug_in,
  output logic [7:0]                           send_data_items,
  output logic [7:0]                           dram_send_items,
  output logic [7:0]                           dram_req_items,
  output logic [7:0]                           core_msg_items,
  output logic [rpu_status_pkg::TAG_WIDTH-1:0] recv_dram_tag,
  output logic                                 recv_dram_tag_v,
  output logic [rpu_status_pkg::INT_COUNT-1:0] interrupts
);

  rpu_status_pkg::rx_addr_e                 addr;
  logic                                     is_events;
  logic [rpu_status_pkg::INT_COUNT-1:0]     int_set;
  logic                                     tag_strobe;

  assign addr      = rpu_status_pkg::rx_addr_e'(intercon_status_addr);
  assign is_events = (addr == rpu_status_pkg::RX_EVENTS);

  // Event word fields, only meaningful on an events cycle
  assign int_set    = is_events ?
                      intercon_status_data[rpu_status_pkg::EVT_INT_LSB +:
                                           rpu_status_pkg::INT_COUNT] : '0;
  assign tag_strobe = is_events && intercon_status_data[rpu_status_pkg::EVT_TAG_V];

  ////////////////////////////////////////////////////////////////////////////
  // Control state

  always_ff @(posedge clk) begin
    if (rst) begin
      recv_dram_tag_v <= 1'b0;
      interrupts      <= '0;
    end else begin
      recv_dram_tag_v <= tag_strobe;
      // Sticky, ack beats a set in the same cycle
      interrupts      <= (interrupts | int_set) & ~int_ack;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Data registers and timer

  always_ff @(posedge clk) begin
    // Free-running unless a half is loaded
    timer <= timer + 64'd1;
    if (tag_strobe) begin
      recv_dram_tag <= intercon_status_data[rpu_status_pkg::TAG_WIDTH-1:0];
    end
    case (addr)
      rpu_status_pkg::RX_CONFIG: begin
        bc_region_size <= intercon_status_data[15:0];
        max_slot_count <= intercon_status_data[23:16];
        core_id        <= intercon_status_data[31:24];
      end
      // Other half holds, no increment on a load cycle
      rpu_status_pkg::RX_TIMER_L: timer <= {timer[63:32], intercon_status_data};
      rpu_status_pkg::RX_TIMER_H: timer <= {intercon_status_data, timer[31:0]};
      rpu_status_pkg::RX_DEBUG_L: debug_in[31:0]  <= intercon_status_data;
      rpu_status_pkg::RX_DEBUG_H: debug_in[63:32] <= intercon_status_data;
      rpu_status_pkg::RX_ITEMS: begin
        send_data_items <= intercon_status_data[7:0];
        dram_send_items <= intercon_status_data[15:8];
        dram_req_items  <= intercon_status_data[23:16];
        core_msg_items  <= intercon_status_data[31:24];
      end
      default: begin
      end
    endcase
  end

endmodule

// ==== src/status_tx.sv ====
/*
 * Outbound status multiplexer
 * Fixed-priority selection of core events onto the status channel
 */

`timescale 1ns/1ps

module status_tx (
  input  logic [31:0] slot_wr_data,
  input  logic        slot_wr_valid,
  output logic        slot_wr_ready,
  input  logic [15:0] lb_tag_len,
  input  logic        tag_len_wr_valid,
  input  logic [63:0] debug_out,
  input  logic        debug_out_l_valid,
  input  logic        debug_out_h_valid,
  input  logic [7:0]  core_errors,
  input  logic [7:0]  mem_fifo_fulls,
  input  logic        ready_to_evict,
  input  logic        core_reset,
  output logic [2:0]  rpu_status_addr,
  output logic [31:0] rpu_status_data
);

  rpu_status_pkg::tx_addr_e sel;

  // Slot writes first, idle word when nothing is pending
  always_comb begin
    if (slot_wr_valid) begin
      sel = rpu_status_pkg::TX_SLOT;
    end else if (tag_len_wr_valid) begin
      sel = rpu_status_pkg::TX_TAG_LEN;
    end else if (debug_out_l_valid) begin
      sel = rpu_status_pkg::TX_DEBUG_L;
    end else if (debug_out_h_valid) begin
      sel = rpu_status_pkg::TX_DEBUG_H;
    end else begin
      sel = rpu_status_pkg::TX_IDLE;
    end
  end

  always_comb begin
    case (sel)
      rpu_status_pkg::TX_SLOT:    rpu_status_data = slot_wr_data;
      rpu_status_pkg::TX_TAG_LEN: rpu_status_data = {16'd0, lb_tag_len};
      rpu_status_pkg::TX_DEBUG_L: rpu_status_data = debug_out[31:0];
      rpu_status_pkg::TX_DEBUG_H: rpu_status_data = debug_out[63:32];
      default: rpu_status_data = {14'd0, core_reset, ready_to_evict,
                                  mem_fifo_fulls, core_errors};
    endcase
  end

  assign rpu_status_addr = sel;
  // Slot writes are never stalled
  assign slot_wr_ready   = 1'b1;

endmodule

// ==== src/rpu_ctrl_top.sv ====
/*
 * RPU controller top level
 * Descriptor path, slot tracking and both status channels for one core
 */

`timescale 1ns/1ps

module rpu_ctrl_top #(
  parameter int SLOT_COUNT = 16,
  parameter int FIFO_DEPTH = 4
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                core_reset,
  // Core descriptor out
  input  logic [63:0]         core_desc_hdr,
  input  logic [63:0]         core_desc_dram_addr,
  input  logic                core_desc_valid,
  output logic                core_desc_ready,
  output logic [63:0]         out_desc,
  output logic                out_desc_2nd,
  output logic                out_desc_valid,
  input  logic                out_desc_ready,
  // Monitored input descriptor
  input  logic [63:0]         in_desc,
  input  logic                in_desc_valid,
  input  logic                in_desc_taken,
  output logic [SLOT_COUNT:1] slots_in_prog,
  // Status from interconnect
  input  logic [2:0]          intercon_status_addr,
  input  logic [31:0]         intercon_status_data,
  input  logic [4:0]          int_ack,
  output logic [15:0]         bc_region_size,
  output logic [7:0]          max_slot_count,
  output logic [7:0]          core_id,
  output logic [63:0]         timer,
  output logic [63:0]         debug_in,
  output logic [7:0]          send_data_items,
  output logic [7:0]          dram_send_items,
  output logic [7:0]          dram_req_items,
  output logic [7:0]          core_msg_items,
  output logic [4:0]          recv_dram_tag,
  output logic                recv_dram_tag_v,
  output logic [4:0]          interrupts,
  // Status to interconnect
  input  logic [31:0]         slot_wr_data,
  input  logic                slot_wr_valid,
  output logic                slot_wr_ready,
  input  logic [15:0]         lb_tag_len,
  input  logic                tag_len_wr_valid,
  input  logic [63:0]         debug_out,
  input  logic                debug_out_l_valid,
  input  logic                debug_out_h_valid,
  input  logic [7:0]          core_errors,
  input  logic [7:0]          mem_fifo_fulls,
  input  logic                ready_to_evict,
  output logic [2:0]          rpu_status_addr,
  output logic [31:0]         rpu_status_data
);

  logic        blk_rst;
  logic [63:0] beat;
  logic        beat_2nd;
  logic        beat_valid;
  logic        beat_ready;

  // Soft core reset clears every block like the system reset
  assign blk_rst = rst | core_reset;

  ////////////////////////////////////////////////////////////////////////////
  // Descriptor path

  desc_merger i_desc_merger (
    .clk, .rst(blk_rst), .core_desc_hdr, .core_desc_dram_addr, .core_desc_valid,
    .core_desc_ready, .beat, .beat_2nd, .beat_valid, .beat_ready
  );

  desc_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_desc_fifo (
    .clk, .rst(blk_rst), .beat, .beat_2nd, .beat_valid, .beat_ready,
    .out_desc, .out_desc_2nd, .out_desc_valid, .out_desc_ready
  );

  // Watches beats leaving the FIFO
  slot_tracker #(.SLOT_COUNT(SLOT_COUNT)) i_slot_tracker (
    .clk, .rst(blk_rst), .in_desc, .in_desc_valid, .in_desc_taken,
    .out_desc, .out_desc_2nd, .out_desc_valid, .out_desc_ready, .slots_in_prog
  );

  ////////////////////////////////////////////////////////////////////////////
  // Status channels

  status_rx i_status_rx (
    .clk, .rst(blk_rst), .intercon_status_addr, .intercon_status_data, .int_ack,
    .bc_region_size, .max_slot_count, .core_id, .timer, .debug_in,
    .send_data_items, .dram_send_items, .dram_req_items, .core_msg_items,
    .recv_dram_tag, .recv_dram_tag_v, .interrupts
  );

  status_tx i_status_tx (
    .slot_wr_data, .slot_wr_valid, .slot_wr_ready, .lb_tag_len, .tag_len_wr_valid,
    .debug_out, .debug_out_l_valid, .debug_out_h_valid, .core_errors,
    .mem_fifo_fulls, .ready_to_evict, .core_reset, .rpu_status_addr, .rpu_status_data
  );

endmodule

// ==== testbench/tb_rpu_ctrl.sv ====
/*
 * RPU controller testbench
 * Random descriptor, slot and status traffic checked against a reference model
 */

`timescale 1ns/1ps

module tb_rpu_ctrl;

  localparam int SLOT_COUNT = 16;
  localparam int FIFO_DEPTH = 4;
  localparam int SLOT_W     = $clog2(SLOT_COUNT + 1);

  // Test lengths
  localparam int DESC_COUNT     = 200;
  localparam int REG_COUNT      = 100;
  localparam int TIMER_ROUNDS   = 20;
  localparam int TIMER_IDLE_MAX = 64;
  localparam int EVT_COUNT      = 200;
  localparam int TX_COUNT       = 200;
  // Up to two beats per descriptor at half output rate
  localparam int STIM_CYCLES = 4 + DESC_COUNT * 4 + REG_COUNT + EVT_COUNT + TX_COUNT +
                               TIMER_ROUNDS * (2 + TIMER_IDLE_MAX);
  localparam int CYCLE_LIMIT = 4 * STIM_CYCLES + 200;

  logic clk, rst, core_reset;
  logic [63:0] core_desc_hdr, core_desc_dram_addr, out_desc, in_desc, debug_in, debug_out;
  logic core_desc_valid, core_desc_ready, out_desc_2nd, out_desc_valid, out_desc_ready;
  logic in_desc_valid, in_desc_taken;
  logic [SLOT_COUNT:1] slots_in_prog;
  logic [2:0] intercon_status_addr, rpu_status_addr;
  logic [31:0] intercon_status_data, slot_wr_data, rpu_status_data;
  logic [4:0] int_ack, recv_dram_tag, interrupts;
  logic [15:0] bc_region_size, lb_tag_len;
  logic [7:0] max_slot_count, core_id, send_data_items, dram_send_items;
  logic [7:0] dram_req_items, core_msg_items, core_errors, mem_fifo_fulls;
  logic [63:0] timer;
  logic recv_dram_tag_v, slot_wr_valid, slot_wr_ready, tag_len_wr_valid;
  logic debug_out_l_valid, debug_out_h_valid, ready_to_evict;

  // Reference model state
  logic [63:0]         exp_data_q[$];
  logic                exp_2nd_q[$];
  logic [SLOT_COUNT:1] slot_model;
  logic [31:0]         lcg_state = 32'h13b4_3452;
  int                  pass_count = 0;
  int                  fail_count = 0;
  int                  cycle_count = 0;

  rpu_ctrl_top #(.SLOT_COUNT(SLOT_COUNT), .FIFO_DEPTH(FIFO_DEPTH)) i_rpu_ctrl_top (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Watchdog
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Test failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Upper bits only since the low LCG bits have short periods
  function automatic int pick_below(input int n);
    logic [31:0] r;
    r = lcg_next();
    return int'(r[31:8]) % n;
  endfunction

  function automatic logic [31:0] random_word();
    logic [31:0] a;
    logic [31:0] b;
    a = lcg_next();
    b = lcg_next();
    return {a[31:16], b[31:16]};
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (expected === actual) begin
      pass_count++;
    end else begin
      $display("ERROR %s expected %h actual %h", name, expected, actual);
      fail_count++;
    end
  endtask

  task automatic check_true(input bit ok, input string what);
    assert (ok) begin
      pass_count++;
    end else begin
      $display("%s", what);
      fail_count++;
    end
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic report_test(input string name, input int fails_before);
    $display("%s: done, %0d errors", name, fail_count - fails_before);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Descriptor merging and slot tracking

  task automatic merge_and_slots();
    int                  sent;
    int                  done;
    int                  fill;
    bit                  holding;
    bit                  on_addr;
    bit                  beat_ok;
    bit                  hdr_dram;
    logic [3:0]          dtype;
    logic [63:0]         head;
    logic                head_2nd;
    logic [SLOT_COUNT:1] set_mask;
    logic [SLOT_COUNT:1] clr_mask;
    sent = 0;
    done = 0;
    fill = 0;
    holding = 0;
    on_addr = 0;
    slot_model = '0;
    while (done < DESC_COUNT || exp_data_q.size() > 0) begin
      // Expected beats queued as soon as a descriptor is presented
      if (!holding && sent < DESC_COUNT && pick_below(4) != 0) begin
        dtype = 4'(pick_below(8));
        core_desc_hdr = {random_word(), random_word()};
        core_desc_hdr[rpu_desc_pkg::TYPE_LSB +: 4] = dtype;
        core_desc_hdr[rpu_desc_pkg::SLOT_LSB +: SLOT_W] = SLOT_W'(1 + pick_below(SLOT_COUNT));
        core_desc_dram_addr = {random_word(), random_word()};
        core_desc_valid = 1'b1;
        exp_data_q.push_back(core_desc_hdr);
        exp_2nd_q.push_back(1'b0);
        // DRAM requests carry their address as a second beat
        if (dtype == 4'd4 || dtype == 4'd5) begin
          exp_data_q.push_back(core_desc_dram_addr);
          exp_2nd_q.push_back(1'b1);
        end
        holding = 1;
        sent++;
      end else if (!holding) begin
        core_desc_valid = 1'b0;
      end
      out_desc_ready = (done >= DESC_COUNT) || (pick_below(2) != 0);
      in_desc = {random_word(), random_word()};
      in_desc[rpu_desc_pkg::SLOT_LSB +: SLOT_W] = SLOT_W'(1 + pick_below(SLOT_COUNT));
      in_desc_valid = (pick_below(2) != 0);
      in_desc_taken = (pick_below(2) != 0);
      @(negedge clk);
      check_value("slots_in_prog", 64'(slot_model), 64'(slots_in_prog));
      // Model of the FIFO fill and of the merger address phase
      beat_ok = (fill < FIFO_DEPTH);
      dtype = core_desc_hdr[rpu_desc_pkg::TYPE_LSB +: 4];
      hdr_dram = (dtype == 4'd4) || (dtype == 4'd5);
      check_value("out_desc_valid", 64'(fill > 0), 64'(out_desc_valid));
      // A DRAM header keeps the core waiting until its address beat
      if (core_desc_valid) begin
        check_value("core_desc_ready", 64'(beat_ok && (on_addr || !hdr_dram)),
                    64'(core_desc_ready));
      end
      set_mask = '0;
      clr_mask = '0;
      if (out_desc_valid && out_desc_ready) begin
        check_true(exp_data_q.size() > 0, "FIFO popped a beat that no descriptor produced");
        if (exp_data_q.size() > 0) begin
          head = exp_data_q.pop_front();
          head_2nd = exp_2nd_q.pop_front();
          check_value("out_desc", head, out_desc);
          check_value("out_desc_2nd", 64'(head_2nd), 64'(out_desc_2nd));
          dtype = head[rpu_desc_pkg::TYPE_LSB +: 4];
          if (!head_2nd && dtype <= 4'd2) begin
            clr_mask[head[rpu_desc_pkg::SLOT_LSB +: SLOT_W]] = 1'b1;
          end
        end
      end
      if (in_desc_valid && in_desc_taken) begin
        set_mask[in_desc[rpu_desc_pkg::SLOT_LSB +: SLOT_W]] = 1'b1;
      end
      // Slot bits move at the coming edge and a clear beats a set
      slot_model = (slot_model | set_mask) & ~clr_mask;
      if (fill > 0 && out_desc_ready) begin
        fill--;
      end
      if (core_desc_valid && beat_ok) begin
        on_addr = hdr_dram && !on_addr;
        fill++;
      end
      if (core_desc_valid && core_desc_ready) begin
        holding = 0;
        done++;
      end
      next_cycle();
    end
    core_desc_valid = 1'b0;
    in_desc_valid = 1'b0;
    @(negedge clk);
    check_value("out_desc_valid", 64'd0, 64'(out_desc_valid));
    check_value("slots_in_prog", 64'(slot_model), 64'(slots_in_prog));
    next_cycle();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Inbound status channel

  task automatic inbound_regs();
    logic [31:0] data;
    int          sel;
    repeat (REG_COUNT) begin
      sel = pick_below(4);
      data = random_word();
      intercon_status_data = data;
      case (sel)
        0:       intercon_status_addr = rpu_status_pkg::RX_CONFIG;
        1:       intercon_status_addr = rpu_status_pkg::RX_DEBUG_L;
        2:       intercon_status_addr = rpu_status_pkg::RX_DEBUG_H;
        default: intercon_status_addr = rpu_status_pkg::RX_ITEMS;
      endcase
      next_cycle();
      case (sel)
        0: begin
          check_value("bc_region_size", 64'(data[15:0]), 64'(bc_region_size));
          check_value("max_slot_count", 64'(data[23:16]), 64'(max_slot_count));
          check_value("core_id", 64'(data[31:24]), 64'(core_id));
        end
        1: check_value("debug_in[31:0]", 64'(data), 64'(debug_in[31:0]));
        2: check_value("debug_in[63:32]", 64'(data), 64'(debug_in[63:32]));
        default: begin
          check_value("send_data_items", 64'(data[7:0]), 64'(send_data_items));
          check_value("dram_send_items", 64'(data[15:8]), 64'(dram_send_items));
          check_value("dram_req_items", 64'(data[23:16]), 64'(dram_req_items));
          check_value("core_msg_items", 64'(data[31:24]), 64'(core_msg_items));
        end
      endcase
    end
    intercon_status_addr = 3'd7;
  endtask

  task automatic timer_count();
    logic [31:0] lo;
    logic [31:0] hi;
    int          idle;
    repeat (TIMER_ROUNDS) begin
      lo = random_word();
      hi = random_word();
      idle = pick_below(TIMER_IDLE_MAX);
      intercon_status_addr = rpu_status_pkg::RX_TIMER_L;
      intercon_status_data = lo;
      next_cycle();
      check_value("timer[31:0]", 64'(lo), 64'(timer[31:0]));
      intercon_status_addr = rpu_status_pkg::RX_TIMER_H;
      intercon_status_data = hi;
      next_cycle();
      // Address 7 is idle so the timer just counts
      intercon_status_addr = 3'd7;
      repeat (idle) next_cycle();
      check_value("timer", {hi, lo} + 64'(idle), timer);
    end
  endtask

  task automatic events_and_tag();
    logic [31:0] data;
    logic [4:0]  ack;
    logic [4:0]  set;
    logic [4:0]  int_model;
    bit          is_evt;
    int_model = '0;
    repeat (EVT_COUNT + 1) begin
      data = random_word();
      is_evt = (pick_below(4) != 0);
      // Acking the bits being set hits the same-cycle case
      if (pick_below(4) == 0) begin
        ack = data[20:16];
      end else begin
        ack = 5'(random_word() & random_word());
      end
      if (is_evt) begin
        intercon_status_addr = rpu_status_pkg::RX_EVENTS;
      end else begin
        intercon_status_addr = 3'd7;
      end
      intercon_status_data = data;
      int_ack = ack;
      set = is_evt ? data[20:16] : 5'd0;
      int_model = (int_model | set) & ~ack;
      next_cycle();
      check_value("interrupts", 64'(int_model), 64'(interrupts));
      check_value("recv_dram_tag_v", 64'(is_evt && data[21]), 64'(recv_dram_tag_v));
      if (is_evt && data[21]) begin
        check_value("recv_dram_tag", 64'(data[4:0]), 64'(recv_dram_tag));
      end
    end
    int_ack = '0;
    intercon_status_addr = 3'd7;
    next_cycle();
    check_value("recv_dram_tag_v", 64'd0, 64'(recv_dram_tag_v));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Outbound status channel

  task automatic outbound_status();
    logic [2:0]  exp_addr;
    logic [31:0] exp_data;
    repeat (TX_COUNT) begin
      slot_wr_data = random_word();
      slot_wr_valid = (pick_below(3) == 0);
      lb_tag_len = 16'(random_word());
      tag_len_wr_valid = (pick_below(3) == 0);
      debug_out = {random_word(), random_word()};
      debug_out_l_valid = (pick_below(3) == 0);
      debug_out_h_valid = (pick_below(3) == 0);
      core_errors = 8'(random_word());
      mem_fifo_fulls = 8'(random_word());
      ready_to_evict = (pick_below(2) != 0);
      core_reset = (pick_below(4) == 0);
      // Slot write, tag/length, debug low, debug high, then the idle word
      if (slot_wr_valid) begin
        exp_addr = rpu_status_pkg::TX_SLOT;
        exp_data = slot_wr_data;
      end else if (tag_len_wr_valid) begin
        exp_addr = rpu_status_pkg::TX_TAG_LEN;
        exp_data = {16'd0, lb_tag_len};
      end else if (debug_out_l_valid) begin
        exp_addr = rpu_status_pkg::TX_DEBUG_L;
        exp_data = debug_out[31:0];
      end else if (debug_out_h_valid) begin
        exp_addr = rpu_status_pkg::TX_DEBUG_H;
        exp_data = debug_out[63:32];
      end else begin
        exp_addr = rpu_status_pkg::TX_IDLE;
        exp_data = {14'd0, core_reset, ready_to_evict, mem_fifo_fulls, core_errors};
      end
      @(negedge clk);
      check_value("rpu_status_addr", 64'(exp_addr), 64'(rpu_status_addr));
      check_value("rpu_status_data", 64'(exp_data), 64'(rpu_status_data));
      check_value("slot_wr_ready", 64'd1, 64'(slot_wr_ready));
      next_cycle();
    end
    slot_wr_valid = 1'b0;
    tag_len_wr_valid = 1'b0;
    debug_out_l_valid = 1'b0;
    debug_out_h_valid = 1'b0;
    core_reset = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    int fails_before;
    rst = 1'b1;
    core_reset = 1'b0;
    core_desc_hdr = '0;
    core_desc_dram_addr = '0;
    core_desc_valid = 1'b0;
    out_desc_ready = 1'b0;
    in_desc = '0;
    in_desc_valid = 1'b0;
    in_desc_taken = 1'b0;
    intercon_status_addr = 3'd7;
    intercon_status_data = '0;
    int_ack = '0;
    slot_wr_data = '0;
    slot_wr_valid = 1'b0;
    lb_tag_len = '0;
    tag_len_wr_valid = 1'b0;
    debug_out = '0;
    debug_out_l_valid = 1'b0;
    debug_out_h_valid = 1'b0;
    core_errors = '0;
    mem_fifo_fulls = '0;
    ready_to_evict = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    fails_before = fail_count;
    check_value("out_desc_valid", 64'd0, 64'(out_desc_valid));
    check_value("slots_in_prog", 64'd0, 64'(slots_in_prog));
    check_value("interrupts", 64'd0, 64'(interrupts));
    check_value("recv_dram_tag_v", 64'd0, 64'(recv_dram_tag_v));
    report_test("reset state", fails_before);

    fails_before = fail_count;
    merge_and_slots();
    report_test("descriptor merging and slot tracking", fails_before);
    fails_before = fail_count;
    inbound_regs();
    report_test("inbound registers", fails_before);
    fails_before = fail_count;
    timer_count();
    report_test("timer", fails_before);
    fails_before = fail_count;
    events_and_tag();
    report_test("interrupts and tag strobe", fails_before);
    fails_before = fail_count;
    outbound_status();
    report_test("outbound status", fails_before);

    $display("Checks: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
src/rpu_status_pkg.sv
src/rpu_desc_pkg.sv
src/desc_merger.sv
src/desc_fifo.sv
src/slot_tracker.sv
src/status_rx.sv
src/status_tx.sv
src/rpu_ctrl_top.sv
testbench/tb_rpu_ctrl.sv

// ==== run.sh ====
#!/bin/sh
# Build the RPU controller testbench with Verilator, run it and look for the pass line
verilator --binary --timing --assert -f verilog.f --top-module tb_rpu_ctrl -o sim_rpu_ctrl \
  && out="$(./obj_dir/sim_rpu_ctrl)" \
  && echo "$out" \
  && echo "$out" | grep -q "^Test passed$" \
  && exit 0 \
  || { echo "Simulation did not pass"; exit 1; }
